//--- csr_pkg.sv
////////////////////////////////////////
// machine CSR constants, enums, views
////////////////////////////////////////

package csr_pkg;

	localparam int DATA_W     = 32;	// csr data width
	localparam int CSR_ADDR_W = 12;	// csr address width

	// csr addresses
	localparam logic [CSR_ADDR_W-1:0] MVENDORID_ADDR       = 12'hF11;
	localparam logic [CSR_ADDR_W-1:0] MARCHID_ADDR         = 12'hF12;
	localparam logic [CSR_ADDR_W-1:0] MIMPID_ADDR          = 12'hF13;
	localparam logic [CSR_ADDR_W-1:0] MHARTID_ADDR         = 12'hF14;
	localparam logic [CSR_ADDR_W-1:0] MSTATUS_ADDR         = 12'h300;
	localparam logic [CSR_ADDR_W-1:0] MISA_ADDR            = 12'h301;
	localparam logic [CSR_ADDR_W-1:0] MEDELEG_ADDR         = 12'h302;
	localparam logic [CSR_ADDR_W-1:0] MIDELEG_ADDR         = 12'h303;
	localparam logic [CSR_ADDR_W-1:0] MIE_ADDR             = 12'h304;
	localparam logic [CSR_ADDR_W-1:0] MTVEC_ADDR           = 12'h305;
	localparam logic [CSR_ADDR_W-1:0] STVEC_ADDR           = 12'h105;
	localparam logic [CSR_ADDR_W-1:0] SATP_ADDR            = 12'h180;
	localparam logic [CSR_ADDR_W-1:0] MIP_ADDR             = 12'h344;
	localparam logic [CSR_ADDR_W-1:0] PMPCFG0_ADDR         = 12'h3A0;
	localparam logic [CSR_ADDR_W-1:0] PMPADDR0_ADDR        = 12'h3B0;
	localparam logic [CSR_ADDR_W-1:0] TCM_CTRL_ADDR        = 12'hBC0;
	localparam logic [CSR_ADDR_W-1:0] DTCM_START_ADDR_ADDR = 12'hBC1;

	localparam logic [25:0]       MISA_RESET       = 26'h000_0100;	// I extension
	localparam logic [DATA_W-1:0] MIMPID_VALUE     = 32'h1000_0000;
	localparam logic [DATA_W-1:0] VECTOR_ENTRY     = 32'h0000_0100;	// mtvec base after reset
	localparam logic [DATA_W-1:0] DTCM_START_RESET = 32'h0001_0000;

	// bit positions
	localparam int MIE_BIT  = 3;	// mstatus
	localparam int MPIE_BIT = 7;
	localparam int MEIE_BIT = 11;	// mie
	localparam int MTIE_BIT = 7;
	localparam int MEIP_BIT = 11;	// mip
	localparam int MTIP_BIT = 7;

	// decoded register id, CSR_NONE for unmapped addresses
	typedef enum logic [4:0] {
		CSR_NONE,
		CSR_MVENDORID,
		CSR_MARCHID,
		CSR_MIMPID,
		CSR_MHARTID,
		CSR_MSTATUS,
		CSR_MISA,
		CSR_MIE,
		CSR_MTVEC,
		CSR_MIP,
		CSR_TCM_CTRL,
		CSR_DTCM_START,
		CSR_DUMMY	// stvec satp pmp deleg, read zero
	} csr_id_e;

	typedef enum logic [1:0] {
		OP_WRITE,
		OP_SET,
		OP_CLEAR
	} csr_op_e;

	typedef struct packed {
		logic mstatus_mie;
		logic mstatus_mpie;
		logic meie;
		logic mtie;
	} status_view_t;

	typedef struct packed {
		logic [25:0]       misa_ext;
		logic [1:0]        mtvec_mode;
		logic [DATA_W-1:0] mtvec_base;
		logic              dtcm_en;
		logic [DATA_W-1:0] dtcm_start_addr;
	} config_view_t;

	// new register image for write / set / clear
	function automatic logic [DATA_W-1:0] csr_update(
		input csr_op_e           op,
		input logic [DATA_W-1:0] cur,
		input logic [DATA_W-1:0] wdata
	);
		case (op)
			OP_SET:   return cur | wdata;
			OP_CLEAR: return cur & ~wdata;
			default:  return wdata;	// plain write
		endcase
	endfunction

endpackage

//--- csr_access_if.sv
////////////////////////////////////////
// decoded csr access bundle
////////////////////////////////////////

`timescale 1ns/1ps

interface csr_access_if;

	csr_pkg::csr_id_e            csr_id;	// decoded register
	csr_pkg::csr_op_e            op;	// write / set / clear
	logic                        wr_en;	// one cycle write strobe
	logic                        rd_en;	// qualifies read data this cycle
	logic [csr_pkg::DATA_W-1:0]  wdata;

	modport decoder (
		output csr_id,
		output op,
		output wr_en,
		output rd_en,
		output wdata
	);

	// register groups
	modport regs (
		input csr_id,
		input op,
		input wr_en,
		input wdata
	);

	modport reader (
		input csr_id,
		input rd_en
	);

endinterface

//--- csr_access_decode.sv
////////////////////////////////////////
// csr address decode, access check
////////////////////////////////////////

`timescale 1ns/1ps

module csr_access_decode (
	input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr,	// csr access address
	input  logic [csr_pkg::DATA_W-1:0]     instr_dec,	// instruction in decode
	input  logic                           csr_rd,	// read request
	input  logic                           csr_wr,	// write request
	input  logic                           csr_rd_valid,
	input  logic                           csr_wr_valid,
	input  logic                           csr_set,
	input  logic                           csr_clr,
	input  logic [csr_pkg::DATA_W-1:0]     write_data,
	output logic                           illegal_access,
	output logic [csr_pkg::DATA_W-1:0]     illegal_instr,
	csr_access_if.decoder                  acc
);

	csr_pkg::csr_id_e id;
	logic id_ro;	// read-only id register
	logic id_wr;	// backed by a writable register

	always_comb
	begin
		case (csr_addr)
			csr_pkg::MVENDORID_ADDR:       id = csr_pkg::CSR_MVENDORID;
			csr_pkg::MARCHID_ADDR:         id = csr_pkg::CSR_MARCHID;
			csr_pkg::MIMPID_ADDR:          id = csr_pkg::CSR_MIMPID;
			csr_pkg::MHARTID_ADDR:         id = csr_pkg::CSR_MHARTID;
			csr_pkg::MSTATUS_ADDR:         id = csr_pkg::CSR_MSTATUS;
			csr_pkg::MISA_ADDR:            id = csr_pkg::CSR_MISA;
			csr_pkg::MIE_ADDR:             id = csr_pkg::CSR_MIE;
			csr_pkg::MTVEC_ADDR:           id = csr_pkg::CSR_MTVEC;
			csr_pkg::MIP_ADDR:             id = csr_pkg::CSR_MIP;
			csr_pkg::TCM_CTRL_ADDR:        id = csr_pkg::CSR_TCM_CTRL;
			csr_pkg::DTCM_START_ADDR_ADDR: id = csr_pkg::CSR_DTCM_START;
			csr_pkg::STVEC_ADDR, csr_pkg::SATP_ADDR,
			csr_pkg::PMPCFG0_ADDR, csr_pkg::PMPADDR0_ADDR,
			csr_pkg::MEDELEG_ADDR, csr_pkg::MIDELEG_ADDR:
				id = csr_pkg::CSR_DUMMY;	// legal, nothing behind it
			default:                       id = csr_pkg::CSR_NONE;
		endcase
	end

	assign id_ro = id inside {csr_pkg::CSR_MVENDORID, csr_pkg::CSR_MARCHID,
		csr_pkg::CSR_MIMPID, csr_pkg::CSR_MHARTID};
	assign id_wr = id inside {csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MISA, csr_pkg::CSR_MIE,
		csr_pkg::CSR_MTVEC, csr_pkg::CSR_TCM_CTRL, csr_pkg::CSR_DTCM_START};

	// unmapped access, or write to an id register
	assign illegal_access = ((csr_rd | csr_wr) & (id == csr_pkg::CSR_NONE)) | (csr_wr & id_ro);
	assign illegal_instr  = illegal_access ? instr_dec : '0;	// report offending instr

	assign acc.csr_id = id;
	assign acc.op     = csr_set ? csr_pkg::OP_SET :
		(csr_clr ? csr_pkg::OP_CLEAR : csr_pkg::OP_WRITE);
	assign acc.wr_en  = csr_wr_valid & id_wr;	// mip and dummies drop the write
	assign acc.rd_en  = csr_rd_valid;
	assign acc.wdata  = write_data;

	// set and clear are exclusive forms of one instruction
	always_comb
	begin
		if (csr_wr_valid)
			assert (!(csr_set && csr_clr))
				else $error("csr_set and csr_clr both high on a valid write");
	end

endmodule

//--- csr_status_regs.sv
////////////////////////////////////////
// mstatus mie/mpie, trap flag, mie bits
////////////////////////////////////////

`timescale 1ns/1ps

module csr_status_regs (
	input  logic                  cpu_clk,
	input  logic                  cpu_rstn,
	input  logic                  trap_taken,	// interrupt entry pulse
	input  logic                  mret,	// return from trap
	csr_access_if.regs            acc,
	output csr_pkg::status_view_t status
);

	logic                       int_entry;	// current trap was an interrupt
	logic [csr_pkg::DATA_W-1:0] cur_img;	// image of the addressed register
	logic [csr_pkg::DATA_W-1:0] new_img;
	logic                       mstatus_wr;
	logic                       mie_wr;

	// rebuild 32-bit image so set/clear work on real bit positions
	always_comb
	begin
		cur_img = '0;
		if (acc.csr_id == csr_pkg::CSR_MSTATUS)
		begin
			cur_img[csr_pkg::MIE_BIT]  = status.mstatus_mie;
			cur_img[csr_pkg::MPIE_BIT] = status.mstatus_mpie;
		end
		else
		begin
			cur_img[csr_pkg::MEIE_BIT] = status.meie;
			cur_img[csr_pkg::MTIE_BIT] = status.mtie;
		end
		new_img = csr_pkg::csr_update(acc.op, cur_img, acc.wdata);
	end

	assign mstatus_wr = acc.wr_en & (acc.csr_id == csr_pkg::CSR_MSTATUS);
	assign mie_wr     = acc.wr_en & (acc.csr_id == csr_pkg::CSR_MIE);

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			int_entry           <= 1'b0;
			status.mstatus_mie  <= 1'b0;	// interrupts off out of reset
			status.mstatus_mpie <= 1'b0;
			status.meie         <= 1'b1;
			status.mtie         <= 1'b1;
		end
		else
		begin
			if (mret)
				int_entry <= 1'b0;
			else if (trap_taken)
				int_entry <= 1'b1;

			// mret beats trap entry beats csr write
			if (mret && int_entry)
			begin
				status.mstatus_mie  <= status.mstatus_mpie;
				status.mstatus_mpie <= 1'b1;
			end
			else if (trap_taken)
			begin
				status.mstatus_mpie <= status.mstatus_mie;	// stack old enable
				status.mstatus_mie  <= 1'b0;
			end
			else if (mstatus_wr)
			begin
				status.mstatus_mie  <= new_img[csr_pkg::MIE_BIT];
				status.mstatus_mpie <= new_img[csr_pkg::MPIE_BIT];
			end

			if (mie_wr)
			begin
				status.meie <= new_img[csr_pkg::MEIE_BIT];
				status.mtie <= new_img[csr_pkg::MTIE_BIT];
			end
		end
	end

	// trap entry and return come from different pipeline events
	a_trap_mret_excl: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
		!(trap_taken && mret))
		else $error("trap_taken and mret high together");

endmodule

//--- csr_config_regs.sv
////////////////////////////////////////
// misa, mtvec, tcm_ctrl, dtcm start
////////////////////////////////////////

`timescale 1ns/1ps

module csr_config_regs (
	input  logic                  cpu_clk,
	input  logic                  cpu_rstn,
	csr_access_if.regs            acc,
	output csr_pkg::config_view_t cfg
);

	logic [csr_pkg::DATA_W-1:0] cur_img;	// addressed register as read
	logic [csr_pkg::DATA_W-1:0] new_img;

	always_comb
	begin
		case (acc.csr_id)
			csr_pkg::CSR_MISA:       cur_img = {6'h0, cfg.misa_ext};
			csr_pkg::CSR_MTVEC:      cur_img = {cfg.mtvec_base[31:2], cfg.mtvec_mode};
			csr_pkg::CSR_TCM_CTRL:   cur_img = {31'h0, cfg.dtcm_en};
			csr_pkg::CSR_DTCM_START: cur_img = cfg.dtcm_start_addr;
			default:                 cur_img = '0;
		endcase
		new_img = csr_pkg::csr_update(acc.op, cur_img, acc.wdata);
	end

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			cfg.misa_ext        <= csr_pkg::MISA_RESET;
			cfg.mtvec_mode      <= 2'h0;	// direct mode
			cfg.mtvec_base      <= csr_pkg::VECTOR_ENTRY;
			cfg.dtcm_en         <= 1'b1;	// dtcm on by default
			cfg.dtcm_start_addr <= csr_pkg::DTCM_START_RESET;
		end
		else if (acc.wr_en)
		begin
			case (acc.csr_id)
				csr_pkg::CSR_MISA:
					cfg.misa_ext <= new_img[25:0];
				csr_pkg::CSR_MTVEC:
				begin
					cfg.mtvec_mode <= new_img[1:0];
					cfg.mtvec_base <= {new_img[31:2], 2'b00};	// base is word aligned
				end
				csr_pkg::CSR_TCM_CTRL:
					cfg.dtcm_en <= new_img[0];
				csr_pkg::CSR_DTCM_START:
					cfg.dtcm_start_addr <= new_img;
				default:
					;	// status group or no register
			endcase
		end
	end

	// unknown write word would poison a register image
	a_wdata_known: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
		acc.wr_en |-> !$isunknown(acc.wdata))
		else $error("write strobe with unknown write data");

endmodule

//--- csr_read_mux.sv
////////////////////////////////////////
// csr read data formatting
////////////////////////////////////////

`timescale 1ns/1ps

module csr_read_mux (
	csr_access_if.reader               acc,
	input  csr_pkg::status_view_t      status,
	input  csr_pkg::config_view_t      cfg,
	input  logic                       meip,	// external irq pending
	input  logic                       mtip,	// timer irq pending
	output logic [csr_pkg::DATA_W-1:0] read_data
);

	logic [csr_pkg::DATA_W-1:0] rdata;	// ungated word

	always_comb
	begin
		rdata = '0;
		case (acc.csr_id)
			csr_pkg::CSR_MISA:
				rdata = {2'h1, 4'h0, cfg.misa_ext};	// mxl=1, rv32
			csr_pkg::CSR_MIMPID:
				rdata = csr_pkg::MIMPID_VALUE;
			csr_pkg::CSR_MSTATUS:
			begin
				rdata[csr_pkg::MIE_BIT]  = status.mstatus_mie;
				rdata[csr_pkg::MPIE_BIT] = status.mstatus_mpie;
			end
			csr_pkg::CSR_MIE:
			begin
				rdata[csr_pkg::MEIE_BIT] = status.meie;
				rdata[csr_pkg::MTIE_BIT] = status.mtie;
			end
			csr_pkg::CSR_MIP:
			begin
				rdata[csr_pkg::MEIP_BIT] = meip;	// live pending levels
				rdata[csr_pkg::MTIP_BIT] = mtip;
			end
			csr_pkg::CSR_MTVEC:
				rdata = {cfg.mtvec_base[31:2], cfg.mtvec_mode};
			csr_pkg::CSR_TCM_CTRL:
				rdata[0] = cfg.dtcm_en;
			csr_pkg::CSR_DTCM_START:
				rdata = cfg.dtcm_start_addr;
			default:
				rdata = '0;	// vendor/arch/hart id, dummies, unmapped
		endcase
	end

	assign read_data = acc.rd_en ? rdata : '0;	// zero outside a valid read

endmodule

//--- machine_csr_top.sv
////////////////////////////////////////
// machine csr block top level
////////////////////////////////////////

`timescale 1ns/1ps

module machine_csr_top (
	input  logic                           cpu_clk,
	input  logic                           cpu_rstn,
	input  logic [csr_pkg::DATA_W-1:0]     instr_dec,
	input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr,
	input  logic                           csr_rd,
	input  logic                           csr_wr,
	input  logic                           csr_rd_valid,
	input  logic                           csr_wr_valid,
	input  logic                           csr_set,
	input  logic                           csr_clr,
	input  logic [csr_pkg::DATA_W-1:0]     write_data,
	input  logic                           meip,
	input  logic                           mtip,
	input  logic                           trap_taken,
	input  logic                           mret,
	output logic [csr_pkg::DATA_W-1:0]     read_data,
	output logic                           illegal_access,
	output logic [csr_pkg::DATA_W-1:0]     illegal_instr,
	output logic                           meie,
	output logic                           mtie,
	output logic                           mstatus_mie,
	output logic [1:0]                     mtvec_mode,
	output logic [csr_pkg::DATA_W-1:0]     mtvec_base,
	output logic                           dtcm_en,	// to mem ctrl
	output logic [csr_pkg::DATA_W-1:0]     dtcm_start_addr
);

	csr_pkg::status_view_t status;
	csr_pkg::config_view_t cfg;

	csr_access_if acc ();	// decoded access, shared by all groups

	csr_access_decode u_decode (
		.csr_addr       (csr_addr),
		.instr_dec      (instr_dec),
		.csr_rd         (csr_rd),
		.csr_wr         (csr_wr),
		.csr_rd_valid   (csr_rd_valid),
		.csr_wr_valid   (csr_wr_valid),
		.csr_set        (csr_set),
		.csr_clr        (csr_clr),
		.write_data     (write_data),
		.illegal_access (illegal_access),
		.illegal_instr  (illegal_instr),
		.acc            (acc.decoder)
	);

	csr_status_regs u_status (
		.cpu_clk    (cpu_clk),
		.cpu_rstn   (cpu_rstn),
		.trap_taken (trap_taken),
		.mret       (mret),
		.acc        (acc.regs),
		.status     (status)
	);

	csr_config_regs u_config (
		.cpu_clk  (cpu_clk),
		.cpu_rstn (cpu_rstn),
		.acc      (acc.regs),
		.cfg      (cfg)
	);

	csr_read_mux u_read_mux (
		.acc       (acc.reader),
		.status    (status),
		.cfg       (cfg),
		.meip      (meip),
		.mtip      (mtip),
		.read_data (read_data)
	);

	// register views out to core and trap logic
	assign meie            = status.meie;
	assign mtie            = status.mtie;
	assign mstatus_mie     = status.mstatus_mie;
	assign mtvec_mode      = cfg.mtvec_mode;
	assign mtvec_base      = cfg.mtvec_base;
	assign dtcm_en         = cfg.dtcm_en;
	assign dtcm_start_addr = cfg.dtcm_start_addr;

endmodule

//--- tb_clock_gen.sv
////////////////////////////////////////
// testbench clock and reset
////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock_gen (
	output logic cpu_clk,
	output logic cpu_rstn
);

	initial
	begin
		cpu_clk = 1'b0;
		forever #2 cpu_clk = ~cpu_clk;	// 4 ns period
	end

	initial
	begin
		cpu_rstn = 1'b0;
		#8 cpu_rstn = 1'b1;	// two cycles, released on a falling edge
	end

endmodule

//--- machine_csr_tb.sv
////////////////////////////////////////
// machine csr testbench, table replay
////////////////////////////////////////

`timescale 1ns/1ps

module machine_csr_tb;

	typedef enum {RD, WR, SET, CLR, TRAP, MRET, WR_RND, SET_RND, CLR_RND} act_e;

	// one table row
	// lv holds meip, mtip and rd_valid
	typedef struct {
		act_e                         act;
		csr_pkg::csr_id_e             id;	// expected decode
		logic [csr_pkg::CSR_ADDR_W-1:0] addr;
		logic [csr_pkg::DATA_W-1:0]   data;
		logic [2:0]                   lv;
		logic [csr_pkg::DATA_W-1:0]   exp_rd;	// read value or readback after update
		logic                         exp_ill;
	} row_t;

	localparam int RST_TIMEOUT = 20;	// cycles to wait for reset release

	logic                           cpu_clk;
	logic                           cpu_rstn;
	logic [csr_pkg::DATA_W-1:0]     instr_dec;
	logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr;
	logic                           csr_rd;
	logic                           csr_wr;
	logic                           csr_rd_valid;
	logic                           csr_wr_valid;
	logic                           csr_set;
	logic                           csr_clr;
	logic [csr_pkg::DATA_W-1:0]     write_data;
	logic                           meip;
	logic                           mtip;
	logic                           trap_taken;
	logic                           mret;
	logic [csr_pkg::DATA_W-1:0]     read_data;
	logic                           illegal_access;
	logic [csr_pkg::DATA_W-1:0]     illegal_instr;
	logic                           meie;
	logic                           mtie;
	logic                           mstatus_mie;
	logic [1:0]                     mtvec_mode;
	logic [csr_pkg::DATA_W-1:0]     mtvec_base;
	logic                           dtcm_en;
	logic [csr_pkg::DATA_W-1:0]     dtcm_start_addr;

	row_t rows[$];
	int   err_cnt;
	int   pass_rows;
	int   fail_rows;
	logic [csr_pkg::DATA_W-1:0] model [0:(1 << csr_pkg::CSR_ADDR_W)-1];	// last known images

	tb_clock_gen clk_gen (
		.cpu_clk  (cpu_clk),
		.cpu_rstn (cpu_rstn)
	);

	machine_csr_top dut (
		.cpu_clk         (cpu_clk),
		.cpu_rstn        (cpu_rstn),
		.instr_dec       (instr_dec),
		.csr_addr        (csr_addr),
		.csr_rd          (csr_rd),
		.csr_wr          (csr_wr),
		.csr_rd_valid    (csr_rd_valid),
		.csr_wr_valid    (csr_wr_valid),
		.csr_set         (csr_set),
		.csr_clr         (csr_clr),
		.write_data      (write_data),
		.meip            (meip),
		.mtip            (mtip),
		.trap_taken      (trap_taken),
		.mret            (mret),
		.read_data       (read_data),
		.illegal_access  (illegal_access),
		.illegal_instr   (illegal_instr),
		.meie            (meie),
		.mtie            (mtie),
		.mstatus_mie     (mstatus_mie),
		.mtvec_mode      (mtvec_mode),
		.mtvec_base      (mtvec_base),
		.dtcm_en         (dtcm_en),
		.dtcm_start_addr (dtcm_start_addr)
	);

	task automatic check_word(input string name, input logic [csr_pkg::DATA_W-1:0] exp,
		input logic [csr_pkg::DATA_W-1:0] act);
		if (act !== exp)
		begin
			$display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_id(input string name, input csr_pkg::csr_id_e exp,
		input csr_pkg::csr_id_e act);
		if (act !== exp)
		begin
			$display("FAIL t=%0t %s expected %s got %s", $time, name, exp.name(), act.name());
			err_cnt++;
		end
	endtask

	task automatic add_row(input act_e act, input csr_pkg::csr_id_e id,
		input logic [csr_pkg::CSR_ADDR_W-1:0] addr, input logic [csr_pkg::DATA_W-1:0] data,
		input logic [2:0] lv, input logic [csr_pkg::DATA_W-1:0] exp_rd, input logic exp_ill);
		row_t r;
		r.act     = act;
		r.id      = id;
		r.addr    = addr;
		r.data    = data;
		r.lv      = lv;
		r.exp_rd  = exp_rd;
		r.exp_ill = exp_ill;
		rows.push_back(r);
	endtask

	// write replaces, set ORs, clear AND-NOTs
	function automatic logic [csr_pkg::DATA_W-1:0] expected_after_op(input act_e act,
		input logic [csr_pkg::DATA_W-1:0] cur, input logic [csr_pkg::DATA_W-1:0] data);
		case (act)
			SET_RND: return cur | data;
			CLR_RND: return cur & ~data;
			default: return data;
		endcase
	endfunction

	task automatic build_table();
		// reset values
		add_row(RD, csr_pkg::CSR_MISA, csr_pkg::MISA_ADDR, 32'h0, 3'b001, 32'h4000_0100, 1'b0);
		add_row(RD, csr_pkg::CSR_MIMPID, csr_pkg::MIMPID_ADDR, 32'h0, 3'b001,
			csr_pkg::MIMPID_VALUE, 1'b0);
		add_row(RD, csr_pkg::CSR_MTVEC, csr_pkg::MTVEC_ADDR, 32'h0, 3'b001,
			csr_pkg::VECTOR_ENTRY, 1'b0);
		add_row(RD, csr_pkg::CSR_MIE, csr_pkg::MIE_ADDR, 32'h0, 3'b001, 32'h0000_0880, 1'b0);
		add_row(RD, csr_pkg::CSR_TCM_CTRL, csr_pkg::TCM_CTRL_ADDR, 32'h0, 3'b001, 32'h1, 1'b0);
		add_row(RD, csr_pkg::CSR_DTCM_START, csr_pkg::DTCM_START_ADDR_ADDR, 32'h0, 3'b001,
			csr_pkg::DTCM_START_RESET, 1'b0);
		add_row(RD, csr_pkg::CSR_MSTATUS, csr_pkg::MSTATUS_ADDR, 32'h0, 3'b001, 32'h0, 1'b0);
		// mtvec with mode in bits 1:0
		add_row(WR, csr_pkg::CSR_MTVEC, csr_pkg::MTVEC_ADDR, 32'h2001, 3'b000, 32'h2001, 1'b0);
		add_row(SET, csr_pkg::CSR_MTVEC, csr_pkg::MTVEC_ADDR, 32'h0102, 3'b000, 32'h2103, 1'b0);
		add_row(CLR, csr_pkg::CSR_MTVEC, csr_pkg::MTVEC_ADDR, 32'h2001, 3'b000, 32'h0102, 1'b0);
		// mie has only bits 11 and 7
		add_row(CLR, csr_pkg::CSR_MIE, csr_pkg::MIE_ADDR, 32'h0800, 3'b000, 32'h0080, 1'b0);
		add_row(SET, csr_pkg::CSR_MIE, csr_pkg::MIE_ADDR, 32'h0800, 3'b000, 32'h0880, 1'b0);
		add_row(WR, csr_pkg::CSR_MIE, csr_pkg::MIE_ADDR, 32'hFFFF_F7FF, 3'b000, 32'h0080, 1'b0);
		add_row(WR, csr_pkg::CSR_MIE, csr_pkg::MIE_ADDR, 32'h0880, 3'b000, 32'h0880, 1'b0);
		add_row(CLR, csr_pkg::CSR_TCM_CTRL, csr_pkg::TCM_CTRL_ADDR, 32'h1, 3'b000, 32'h0, 1'b0);
		add_row(SET, csr_pkg::CSR_TCM_CTRL, csr_pkg::TCM_CTRL_ADDR, 32'hFFFF_FFFF, 3'b000,
			32'h1, 1'b0);
		add_row(WR, csr_pkg::CSR_DTCM_START, csr_pkg::DTCM_START_ADDR_ADDR, 32'h0002_0000,
			3'b000, 32'h0002_0000, 1'b0);
		add_row(SET, csr_pkg::CSR_DTCM_START, csr_pkg::DTCM_START_ADDR_ADDR, 32'h0000_00F0,
			3'b000, 32'h0002_00F0, 1'b0);
		add_row(CLR, csr_pkg::CSR_DTCM_START, csr_pkg::DTCM_START_ADDR_ADDR, 32'h0002_0000,
			3'b000, 32'h0000_00F0, 1'b0);
		// random data checked against the model image
		add_row(WR_RND, csr_pkg::CSR_DTCM_START, csr_pkg::DTCM_START_ADDR_ADDR, 32'h0, 3'b000,
			32'h0, 1'b0);
		add_row(SET_RND, csr_pkg::CSR_DTCM_START, csr_pkg::DTCM_START_ADDR_ADDR, 32'h0, 3'b000,
			32'h0, 1'b0);
		add_row(CLR_RND, csr_pkg::CSR_DTCM_START, csr_pkg::DTCM_START_ADDR_ADDR, 32'h0, 3'b000,
			32'h0, 1'b0);
		add_row(WR_RND, csr_pkg::CSR_MTVEC, csr_pkg::MTVEC_ADDR, 32'h0, 3'b000, 32'h0, 1'b0);
		add_row(CLR_RND, csr_pkg::CSR_MTVEC, csr_pkg::MTVEC_ADDR, 32'h0, 3'b000, 32'h0, 1'b0);
		add_row(WR, csr_pkg::CSR_MTVEC, csr_pkg::MTVEC_ADDR, csr_pkg::VECTOR_ENTRY, 3'b000,
			csr_pkg::VECTOR_ENTRY, 1'b0);
		// illegal and dummy accesses
		// 0x341 was mepc
		add_row(RD, csr_pkg::CSR_NONE, 12'h341, 32'h0, 3'b001, 32'h0, 1'b1);
		add_row(WR, csr_pkg::CSR_MVENDORID, csr_pkg::MVENDORID_ADDR, 32'hDEAD_BEEF, 3'b000,
			32'h0, 1'b1);
		add_row(RD, csr_pkg::CSR_DUMMY, csr_pkg::STVEC_ADDR, 32'h0, 3'b001, 32'h0, 1'b0);
		add_row(RD, csr_pkg::CSR_DUMMY, csr_pkg::PMPCFG0_ADDR, 32'h0, 3'b001, 32'h0, 1'b0);
		// interrupt entry and mret
		add_row(WR, csr_pkg::CSR_MSTATUS, csr_pkg::MSTATUS_ADDR, 32'h8, 3'b000, 32'h8, 1'b0);
		add_row(TRAP, csr_pkg::CSR_MSTATUS, csr_pkg::MSTATUS_ADDR, 32'h0, 3'b000, 32'h80, 1'b0);
		add_row(MRET, csr_pkg::CSR_MSTATUS, csr_pkg::MSTATUS_ADDR, 32'h0, 3'b000, 32'h88, 1'b0);
		add_row(WR, csr_pkg::CSR_MSTATUS, csr_pkg::MSTATUS_ADDR, 32'h80, 3'b000, 32'h80, 1'b0);
		add_row(MRET, csr_pkg::CSR_MSTATUS, csr_pkg::MSTATUS_ADDR, 32'h0, 3'b000, 32'h80, 1'b0);
		// live mip levels then reads without valid
		add_row(RD, csr_pkg::CSR_MIP, csr_pkg::MIP_ADDR, 32'h0, 3'b101, 32'h0800, 1'b0);
		add_row(RD, csr_pkg::CSR_MIP, csr_pkg::MIP_ADDR, 32'h0, 3'b011, 32'h0080, 1'b0);
		add_row(RD, csr_pkg::CSR_MIP, csr_pkg::MIP_ADDR, 32'h0, 3'b111, 32'h0880, 1'b0);
		add_row(RD, csr_pkg::CSR_MISA, csr_pkg::MISA_ADDR, 32'h0, 3'b000, 32'h0, 1'b0);
		add_row(RD, csr_pkg::CSR_MIP, csr_pkg::MIP_ADDR, 32'h0, 3'b110, 32'h0, 1'b0);
	endtask

	task automatic drive_row(input row_t r, input logic [csr_pkg::DATA_W-1:0] data);
		logic is_wr;
		is_wr = r.act inside {WR, SET, CLR, WR_RND, SET_RND, CLR_RND};
		csr_addr     <= r.addr;
		instr_dec    <= {r.addr, 20'h02073};	// csrrs encoding with this address
		csr_rd       <= (r.act == RD);
		csr_rd_valid <= (r.act == RD) & r.lv[0];
		csr_wr       <= is_wr;
		csr_wr_valid <= is_wr;
		csr_set      <= r.act inside {SET, SET_RND};
		csr_clr      <= r.act inside {CLR, CLR_RND};
		write_data   <= data;
		meip         <= r.lv[2];
		mtip         <= r.lv[1];
		trap_taken   <= (r.act == TRAP);	// single cycle pulse
		mret         <= (r.act == MRET);
	endtask

	// plain valid read of the same address
	task automatic drive_readback(input row_t r);
		csr_rd       <= 1'b1;
		csr_rd_valid <= 1'b1;
		csr_wr       <= 1'b0;
		csr_wr_valid <= 1'b0;
		csr_set      <= 1'b0;
		csr_clr      <= 1'b0;
		trap_taken   <= 1'b0;
		mret         <= 1'b0;
		csr_addr     <= r.addr;
	endtask

	// output ports follow the readback image
	task automatic check_ports(input logic [csr_pkg::CSR_ADDR_W-1:0] addr,
		input logic [csr_pkg::DATA_W-1:0] exp);
		case (addr)
			csr_pkg::MTVEC_ADDR:
			begin
				check_word("mtvec_mode", {30'h0, exp[1:0]}, {30'h0, mtvec_mode});
				check_word("mtvec_base", {exp[31:2], 2'b00}, mtvec_base);
			end
			csr_pkg::MIE_ADDR:
			begin
				check_flag("meie", exp[csr_pkg::MEIE_BIT], meie);
				check_flag("mtie", exp[csr_pkg::MTIE_BIT], mtie);
			end
			csr_pkg::TCM_CTRL_ADDR:
				check_flag("dtcm_en", exp[0], dtcm_en);
			csr_pkg::DTCM_START_ADDR_ADDR:
				check_word("dtcm_start_addr", exp, dtcm_start_addr);
			csr_pkg::MSTATUS_ADDR:
				check_flag("mstatus_mie", exp[csr_pkg::MIE_BIT], mstatus_mie);
			default:
				;	// no port behind it
		endcase
	endtask

	task automatic check_reset_ports();
		int errs_before;
		errs_before = err_cnt;
		@(negedge cpu_clk);
		check_flag("meie", 1'b1, meie);
		check_flag("mtie", 1'b1, mtie);
		check_flag("dtcm_en", 1'b1, dtcm_en);
		check_flag("mstatus_mie", 1'b0, mstatus_mie);
		check_word("mtvec_base", csr_pkg::VECTOR_ENTRY, mtvec_base);
		check_flag("illegal_access", 1'b0, illegal_access);
		if (err_cnt == errs_before)
			pass_rows++;
		else
			fail_rows++;
		$display("reset ports: %s", (err_cnt == errs_before) ? "pass" : "mismatch");
	endtask

	task automatic run_rows();
		row_t                       r;
		logic [csr_pkg::DATA_W-1:0] data;
		logic [csr_pkg::DATA_W-1:0] exp;
		logic [csr_pkg::DATA_W-1:0] instr;
		int                         errs_before;
		foreach (rows[i])
		begin
			r           = rows[i];
			errs_before = err_cnt;
			data        = r.data;
			exp         = r.exp_rd;
			instr       = {r.addr, 20'h02073};
			if (r.act inside {WR_RND, SET_RND, CLR_RND})
			begin
				data = $urandom;
				exp  = expected_after_op(r.act, model[r.addr], data);
			end
			@(posedge cpu_clk);
			drive_row(r, data);
			@(negedge cpu_clk);	// combinational results in the same cycle
			if (r.act == RD)
			begin
				check_id("csr_id", r.id, dut.acc.csr_id);
				check_word("read_data", exp, read_data);
				check_flag("illegal_access", r.exp_ill, illegal_access);
				check_word("illegal_instr", r.exp_ill ? instr : 32'h0, illegal_instr);
			end
			else if (r.act != TRAP && r.act != MRET)
			begin
				check_id("csr_id", r.id, dut.acc.csr_id);
				check_flag("illegal_access", r.exp_ill, illegal_access);
				check_word("illegal_instr", r.exp_ill ? instr : 32'h0, illegal_instr);
			end
			if (r.act != RD)
			begin
				@(posedge cpu_clk);
				drive_readback(r);
				@(negedge cpu_clk);	// register effect one cycle later
				check_word("read_data", exp, read_data);
				check_flag("illegal_access", 1'b0, illegal_access);
				check_ports(r.addr, exp);
			end
			if (!r.exp_ill && (r.act != RD || r.lv[0]))
				model[r.addr] = exp;
			if (err_cnt == errs_before)
				pass_rows++;
			else
				fail_rows++;
			$display("row %0d %s addr %h: %s", i, r.act.name(), r.addr,
				(err_cnt == errs_before) ? "pass" : "mismatch");
		end
		@(posedge cpu_clk);
		csr_rd       <= 1'b0;	// back to idle
		csr_rd_valid <= 1'b0;
	endtask

	initial
	begin
		int cnt;
		instr_dec    = '0;
		csr_addr     = '0;
		csr_rd       = 1'b0;
		csr_wr       = 1'b0;
		csr_rd_valid = 1'b0;
		csr_wr_valid = 1'b0;
		csr_set      = 1'b0;
		csr_clr      = 1'b0;
		write_data   = '0;
		meip         = 1'b0;
		mtip         = 1'b0;
		trap_taken   = 1'b0;
		mret         = 1'b0;
		err_cnt      = 0;
		pass_rows    = 0;
		fail_rows    = 0;
		void'($urandom(86));
		build_table();
		cnt = 0;
		while (cpu_rstn !== 1'b1 && cnt < RST_TIMEOUT)
		begin
			@(posedge cpu_clk);
			cnt++;
		end
		if (cpu_rstn !== 1'b1)
		begin
			$display("reset was not released within %0d cycles", RST_TIMEOUT);
			$display("TEST FAILED");
			$finish;
		end
		else
		begin
			check_reset_ports();
			run_rows();
			$display("tests passed %0d, failed %0d, check errors %0d",
				pass_rows, fail_rows, err_cnt);
			if (err_cnt == 0)
				$display("TEST OK");
			else
				$display("TEST FAILED");
			$finish;
		end
	end

endmodule

//--- verilog.f
csr_pkg.sv
csr_access_if.sv
csr_access_decode.sv
csr_status_regs.sv
csr_config_regs.sv
csr_read_mux.sv
machine_csr_top.sv
tb_clock_gen.sv
machine_csr_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the machine csr testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module machine_csr_tb -o machine_csr_sim
./obj_dir/machine_csr_sim > sim.log 2>&1
cat sim.log

if grep -q '^TEST OK$' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
